// ==== dmmu_pkg.sv ====
// Shared widths, SPR address fields and TLB entry layouts for the data MMU, referenced by scope
package dmmu_pkg;

  ////////////////////////////////////////
  // Address and bus widths
  ////////////////////////////////////////

  // Virtual/physical address and SPR data width
  localparam int ADDR_W     = 32;
  // SPR bus address width
  localparam int SPR_ADDR_W = 16;

  // TLB geometry, 64 sets of 8 KB pages
  localparam int SET_W     = 6;
  localparam int PAGE_BITS = 13;
  localparam int VPN_W     = ADDR_W - PAGE_BITS;
  localparam int PPN_W     = ADDR_W - PAGE_BITS;

  ////////////////////////////////////////
  // SPR address decode
  ////////////////////////////////////////

  // Group number sits in address bits 15..11
  localparam logic [4:0] SPR_GROUP_DMMU = 5'd1;
  // Set -> translate entry, clear -> match entry
  localparam int SPR_TRANS_BIT = 7;

  ////////////////////////////////////////
  // TLB entry formats
  ////////////////////////////////////////

  // Access enables, same order as translate bits 9..6
  typedef struct packed {
    logic swe;   // Supervisor write
    logic sre;   // Supervisor read
    logic uwe;   // User write
    logic ure;   // User read
  } perm_t;

  // Match entry, compared against the virtual page
  typedef struct packed {
    logic [VPN_W-1:0] vpn;
    logic [11:0]      rsvd;
    logic             valid;
  } match_entry_t;

  // Translate entry, supplies physical page and attributes
  typedef struct packed {
    logic [PPN_W-1:0] ppn;
    logic [2:0]       rsvd;
    perm_t            perm;
    logic             dirty;
    logic             accessed;
    logic             wom;   // Weakly-ordered memory
    logic             wbc;   // Write-back cache
    logic             ci;    // Cache inhibit, bit 1
    logic             cc;    // Cache coherent
  } trans_entry_t;

endpackage

// ==== dmmu_spr_if.sv ====
// SPR side-band bundle from the address decoder to the TLB lookup, instantiated in the MMU top
`timescale 1ns/1ps

interface dmmu_spr_if;

  // Combinational selects for the current strobe
  logic match_cs;
  logic trans_cs;

  // Bus write enable and write data
  logic                       we;
  logic [dmmu_pkg::ADDR_W-1:0] wdata;

  // Set index taken from SPR address bits 5..0
  logic [dmmu_pkg::SET_W-1:0] set_idx;

  // Selects delayed one clock, steer read-back data
  logic match_rd_r;
  logic trans_rd_r;

  // Decoder side drives everything
  modport decoder (
    output match_cs, trans_cs, we, wdata, set_idx, match_rd_r, trans_rd_r
  );

  // Lookup side only consumes
  modport lookup (
    input match_cs, trans_cs, we, wdata, set_idx, match_rd_r, trans_rd_r
  );

endinterface

// ==== dmmu_spr_decode.sv ====
// SPR bus address decoder for the TLB entries, generates selects and the bus acknowledge
`timescale 1ns/1ps

module dmmu_spr_decode (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [dmmu_pkg::SPR_ADDR_W-1:0] spr_bus_addr_i,
  input  logic                            spr_bus_we_i,
  input  logic                            spr_bus_stb_i,
  input  logic [dmmu_pkg::ADDR_W-1:0]     spr_bus_dat_i,
  output logic                            spr_bus_ack_o,
  dmmu_spr_if.decoder                     spr
);

  logic grp_hit;
  logic tlb_area;
  logic match_cs;
  logic trans_cs;
  logic ack_r;
  logic match_rd_r;
  logic trans_rd_r;

  ////////////////////////////////////////
  // Address decode
  ////////////////////////////////////////

  // Group field in the top five address bits
  assign grp_hit = spr_bus_addr_i[dmmu_pkg::SPR_ADDR_W-1:11] == dmmu_pkg::SPR_GROUP_DMMU;

  // TLB entries live where bits 10..9 are nonzero
  // way index bits are ignored, single way only
  assign tlb_area = |spr_bus_addr_i[10:9];

  assign match_cs = spr_bus_stb_i & grp_hit & tlb_area &
                    ~spr_bus_addr_i[dmmu_pkg::SPR_TRANS_BIT];
  assign trans_cs = spr_bus_stb_i & grp_hit & tlb_area &
                    spr_bus_addr_i[dmmu_pkg::SPR_TRANS_BIT];

  ////////////////////////////////////////
  // Registered selects and acknowledge
  ////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      ack_r      <= 1'b0;
      match_rd_r <= 1'b0;
      trans_rd_r <= 1'b0;
    end else begin
      ack_r      <= spr_bus_stb_i & grp_hit;
      match_rd_r <= match_cs;
      trans_rd_r <= trans_cs;
    end
  end

  // Ack one cycle after strobe, drops as soon as strobe does
  assign spr_bus_ack_o = ack_r & spr_bus_stb_i & grp_hit;

  // Drive the bundle towards the lookup
  assign spr.match_cs   = match_cs;
  assign spr.trans_cs   = trans_cs;
  assign spr.we         = spr_bus_we_i;
  assign spr.wdata      = spr_bus_dat_i;
  assign spr.set_idx    = spr_bus_addr_i[dmmu_pkg::SET_W-1:0];
  assign spr.match_rd_r = match_rd_r;
  assign spr.trans_rd_r = trans_rd_r;

  // Registered read selects only hold if the master kept the access still
  a_ack_held: assert property (@(posedge clk) disable iff (rst)
    spr_bus_ack_o |-> $stable(spr_bus_addr_i) && $stable(spr_bus_we_i))
    else $error("SPR address or write enable changed before ack");

  // RAM writes on every strobed edge, so write data must not move
  a_wdata_held: assert property (@(posedge clk) disable iff (rst)
    spr_bus_ack_o && spr_bus_we_i |-> $stable(spr_bus_dat_i))
    else $error("SPR write data changed before ack");

endmodule

// ==== dmmu_tlb_ram.sv ====
// Single-port synchronous-read TLB storage, instantiated once per entry kind
`timescale 1ns/1ps

module dmmu_tlb_ram #(
  parameter type entry_t = logic [dmmu_pkg::ADDR_W-1:0]
) (
  input  logic                       clk,
  input  logic [dmmu_pkg::SET_W-1:0] addr_i,
  input  logic                       we_i,
  input  entry_t                     din_i,
  output entry_t                     dout_o
);

  localparam int DEPTH = 1 << dmmu_pkg::SET_W;

  // One entry per set, contents undefined until software fills them
  entry_t mem [0:DEPTH-1];

  ////////////////////////////////////////
  // Write and registered read
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem[addr_i] <= din_i;
      // Write-first, new entry shows on the output
      dout_o      <= din_i;
    end else begin
      dout_o      <= mem[addr_i];
    end
  end

endmodule

// ==== dmmu_tlb_lookup.sv ====
// TLB match/translate RAMs, tag compare and physical address forming, plus SPR read-back
`timescale 1ns/1ps

module dmmu_tlb_lookup (
  input  logic                        clk,
  input  logic                        rst,
  input  logic [dmmu_pkg::ADDR_W-1:0] virt_addr_i,
  input  logic [dmmu_pkg::ADDR_W-1:0] virt_addr_match_i,
  dmmu_spr_if.lookup                  spr,
  output logic [dmmu_pkg::ADDR_W-1:0] phys_addr_o,
  output logic                        cache_inhibit_o,
  output logic                        hit_o,
  output dmmu_pkg::perm_t             perm_o,
  output logic [dmmu_pkg::ADDR_W-1:0] spr_dat_o
);

  logic [dmmu_pkg::SET_W-1:0] lookup_set;
  logic [dmmu_pkg::SET_W-1:0] match_addr;
  logic [dmmu_pkg::SET_W-1:0] trans_addr;
  dmmu_pkg::match_entry_t     match_q;
  dmmu_pkg::trans_entry_t     trans_q;

  ////////////////////////////////////////
  // RAM address steering
  ////////////////////////////////////////

  // Set index just above the page offset
  assign lookup_set = virt_addr_i[dmmu_pkg::PAGE_BITS +: dmmu_pkg::SET_W];

  // SPR access takes the RAM over for its cycle
  assign match_addr = spr.match_cs ? spr.set_idx : lookup_set;
  assign trans_addr = spr.trans_cs ? spr.set_idx : lookup_set;

  dmmu_tlb_ram #(.entry_t(dmmu_pkg::match_entry_t)) match_ram (
    .clk    (clk),
    .addr_i (match_addr),
    .we_i   (spr.match_cs & spr.we),
    .din_i  (dmmu_pkg::match_entry_t'(spr.wdata)),
    .dout_o (match_q)
  );

  dmmu_tlb_ram #(.entry_t(dmmu_pkg::trans_entry_t)) trans_ram (
    .clk    (clk),
    .addr_i (trans_addr),
    .we_i   (spr.trans_cs & spr.we),
    .din_i  (dmmu_pkg::trans_entry_t'(spr.wdata)),
    .dout_o (trans_q)
  );

  ////////////////////////////////////////
  // Tag compare and translation
  ////////////////////////////////////////

  // Compare against the address held over from the previous cycle
  assign hit_o = match_q.valid &&
                 (match_q.vpn == virt_addr_match_i[dmmu_pkg::ADDR_W-1:dmmu_pkg::PAGE_BITS]);

  always_comb begin
    // Miss passes the low 24 bits through, no access rights
    phys_addr_o     = {{(dmmu_pkg::ADDR_W-24){1'b0}}, virt_addr_match_i[23:0]};
    cache_inhibit_o = 1'b0;
    perm_o          = '0;
    if (hit_o) begin
      phys_addr_o     = {trans_q.ppn, virt_addr_match_i[dmmu_pkg::PAGE_BITS-1:0]};
      cache_inhibit_o = trans_q.ci;
      perm_o          = trans_q.perm;
    end
  end

  // Read-back follows the select registered with the access
  assign spr_dat_o = spr.match_rd_r ? match_q :
                     spr.trans_rd_r ? trans_q : '0;

  // A hit must come from a written translate entry
  a_hit_known: assert property (@(posedge clk) disable iff (rst)
    hit_o |-> !$isunknown(phys_addr_o))
    else $error("hit with unknown physical address");

endmodule

// ==== dmmu_access_check.sv ====
// Page-fault decision from the hit entry's permissions, the operation and the privilege mode
`timescale 1ns/1ps

module dmmu_access_check (
  input  logic            hit_i,
  input  dmmu_pkg::perm_t perm_i,
  input  logic            op_load_i,
  input  logic            op_store_i,
  input  logic            supervisor_mode_i,
  output logic            tlb_miss_o,
  output logic            pagefault_o
);

  logic rd_ok;
  logic wr_ok;

  ////////////////////////////////////////
  // Permission select by mode
  ////////////////////////////////////////

  always_comb begin
    if (supervisor_mode_i) begin
      rd_ok = perm_i.sre;
      wr_ok = perm_i.swe;
    end else begin
      rd_ok = perm_i.ure;
      wr_ok = perm_i.uwe;
    end
  end

  // Fault on any requested access without its enable
  // perms are zero on a miss, so a miss faults too
  assign pagefault_o = (op_store_i & ~wr_ok) | (op_load_i & ~rd_ok);

  assign tlb_miss_o = ~hit_i;

  // LSU issues at most one operation per access
  a_op_excl: assert final (!(op_load_i && op_store_i))
    else $error("load and store requested together");

endmodule

// ==== dmmu_top.sv ====
// Data MMU top level, joins SPR decode, TLB lookup and access check behind plain ports
`timescale 1ns/1ps

module dmmu_top (
  input  logic                            clk,
  input  logic                            rst,

  // Lookup request
  input  logic [dmmu_pkg::ADDR_W-1:0]     virt_addr_i,
  input  logic [dmmu_pkg::ADDR_W-1:0]     virt_addr_match_i,
  input  logic                            op_load_i,
  input  logic                            op_store_i,
  input  logic                            supervisor_mode_i,

  // Lookup results, one cycle after virt_addr_i
  output logic [dmmu_pkg::ADDR_W-1:0]     phys_addr_o,
  output logic                            cache_inhibit_o,
  output logic                            tlb_miss_o,
  output logic                            pagefault_o,

  // SPR bus
  input  logic [dmmu_pkg::SPR_ADDR_W-1:0] spr_bus_addr_i,
  input  logic                            spr_bus_we_i,
  input  logic                            spr_bus_stb_i,
  input  logic [dmmu_pkg::ADDR_W-1:0]     spr_bus_dat_i,
  output logic [dmmu_pkg::ADDR_W-1:0]     spr_bus_dat_o,
  output logic                            spr_bus_ack_o
);

  logic            hit;
  dmmu_pkg::perm_t perm;

  dmmu_spr_if spr_if ();

  ////////////////////////////////////////
  // Decode, execute, result
  ////////////////////////////////////////

  dmmu_spr_decode u_decode (
    .clk            (clk),
    .rst            (rst),
    .spr_bus_addr_i (spr_bus_addr_i),
    .spr_bus_we_i   (spr_bus_we_i),
    .spr_bus_stb_i  (spr_bus_stb_i),
    .spr_bus_dat_i  (spr_bus_dat_i),
    .spr_bus_ack_o  (spr_bus_ack_o),
    .spr            (spr_if.decoder)
  );

  dmmu_tlb_lookup u_lookup (
    .clk               (clk),
    .rst               (rst),
    .virt_addr_i       (virt_addr_i),
    .virt_addr_match_i (virt_addr_match_i),
    .spr               (spr_if.lookup),
    .phys_addr_o       (phys_addr_o),
    .cache_inhibit_o   (cache_inhibit_o),
    .hit_o             (hit),
    .perm_o            (perm),
    .spr_dat_o         (spr_bus_dat_o)
  );

  dmmu_access_check u_check (
    .hit_i             (hit),
    .perm_i            (perm),
    .op_load_i         (op_load_i),
    .op_store_i        (op_store_i),
    .supervisor_mode_i (supervisor_mode_i),
    .tlb_miss_o        (tlb_miss_o),
    .pagefault_o       (pagefault_o)
  );

endmodule

// ==== tb_dmmu.sv ====
// Self-checking testbench for the data MMU, fills the TLB over SPR and checks lookups against a model
`timescale 1ns/1ps

module tb_dmmu;

  // Roughly twice the SPR traffic plus lookups
  localparam int CYCLE_LIMIT = 3000;

  logic        clk = 1'b0;
  logic        rst;
  logic [31:0] virt_addr_i;
  logic [31:0] virt_addr_match_i;
  logic        op_load_i;
  logic        op_store_i;
  logic        supervisor_mode_i;
  logic [31:0] phys_addr_o;
  logic        cache_inhibit_o;
  logic        tlb_miss_o;
  logic        pagefault_o;
  logic [15:0] spr_bus_addr_i;
  logic        spr_bus_we_i;
  logic        spr_bus_stb_i;
  logic [31:0] spr_bus_dat_i;
  logic [31:0] spr_bus_dat_o;
  logic        spr_bus_ack_o;

  // Reference copy of every entry written over SPR
  logic [31:0] m_match [0:63];
  logic [31:0] m_trans [0:63];
  logic [31:0] exp_rd;
  logic [31:0] rnd;
  logic        lk_chk;
  logic        pend_v;
  logic        pend_ld;
  logic        pend_st;
  logic        pend_sup;
  int          err_cnt;
  int          spr_cnt;
  int          lk_cnt;
  int          cycle_cnt;

  wire in_grp = spr_bus_addr_i[15:11] == dmmu_pkg::SPR_GROUP_DMMU;

  dmmu_top uut (.*);

  always #2 clk = ~clk;

  ////////////////////////////////////////
  // Reference rules and helpers
  ////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Group 1, TLB area via bit 9, bit 7 picks translate
  function automatic logic [15:0] tlb_spr_addr(input logic trans, input logic [5:0] set);
    return {dmmu_pkg::SPR_GROUP_DMMU, 2'b01, 1'b0, trans, 1'b0, set};
  endfunction

  function automatic logic ref_hit(input logic [31:0] va);
    logic [31:0] m;
    m = m_match[va[18:13]];
    return m[0] && (m[31:13] == va[31:13]);
  endfunction

  function automatic logic [31:0] ref_pa(input logic [31:0] va);
    if (ref_hit(va))
      return {m_trans[va[18:13]][31:13], va[12:0]};
    return {8'h00, va[23:0]};
  endfunction

  function automatic logic ref_ci(input logic [31:0] va);
    return ref_hit(va) && m_trans[va[18:13]][1];
  endfunction

  // Enables in bits 9..6 as swe, sre, uwe, ure
  function automatic logic ref_fault(input logic [31:0] va, input logic ld, input logic st,
                                     input logic sup);
    logic [31:0] t;
    logic        rd;
    logic        wr;
    t  = ref_hit(va) ? m_trans[va[18:13]] : 32'h0;
    rd = sup ? t[8] : t[6];
    wr = sup ? t[9] : t[7];
    return (st && !wr) || (ld && !rd);
  endfunction

  task automatic note_mismatch(input string sig, input logic [31:0] exp, input logic [31:0] act);
    err_cnt++;
    $display("[ERROR] %0t ns %s expected %h actual %h", $time, sig, exp, act);
  endtask

  task automatic note_failure(input string msg);
    err_cnt++;
    $display("%0t ns: %s", $time, msg);
  endtask

  // One strobe held until ack, then one idle cycle so the registered ack clears
  task automatic spr_access(input logic [15:0] addr, input logic we, input logic [31:0] data);
    int waited;
    waited         = 0;
    spr_bus_addr_i = addr;
    spr_bus_we_i   = we;
    spr_bus_dat_i  = data;
    spr_bus_stb_i  = 1'b1;
    while (!spr_bus_ack_o && waited < 8) begin
      @(posedge clk);
      #0.5;
      waited++;
    end
    if (!spr_bus_ack_o)
      note_failure("SPR access got no acknowledge");
    // Hold over the edge where ack and data get sampled
    @(posedge clk);
    #0.5;
    spr_bus_stb_i = 1'b0;
    spr_bus_we_i  = 1'b0;
    @(posedge clk);
    #0.5;
    spr_cnt++;
  endtask

  // Strobe that must stay unanswered for a few cycles
  task automatic strobe_no_ack(input logic [15:0] addr);
    spr_bus_addr_i = addr;
    spr_bus_stb_i  = 1'b1;
    repeat (4) @(posedge clk);
    #0.5;
    spr_bus_stb_i = 1'b0;
    @(posedge clk);
    #0.5;
  endtask

  // New address goes in, previous one moves to the match stage
  task automatic lookup(input logic [31:0] va, input logic ld, input logic st,
                        input logic sup, input logic valid);
    virt_addr_match_i = virt_addr_i;
    op_load_i         = pend_ld;
    op_store_i        = pend_st;
    supervisor_mode_i = pend_sup;
    lk_chk            = pend_v;
    virt_addr_i       = va;
    pend_ld           = ld;
    pend_st           = st;
    pend_sup          = sup;
    pend_v            = valid;
    if (lk_chk)
      lk_cnt++;
    @(posedge clk);
    #0.5;
  endtask

  ////////////////////////////////////////
  // Checks
  ////////////////////////////////////////

  a_ack_delay: assert property (@(posedge clk) disable iff (rst)
    $rose(spr_bus_stb_i) && in_grp |-> !spr_bus_ack_o ##1 spr_bus_ack_o)
    else note_failure("ack did not rise exactly one cycle after the strobe");

  a_no_ack: assert property (@(posedge clk) disable iff (rst)
    spr_bus_stb_i && !in_grp |-> !spr_bus_ack_o)
    else note_failure("ack raised for an address outside group 1");

  a_rdata: assert property (@(posedge clk) disable iff (rst)
    spr_bus_ack_o && !spr_bus_we_i |-> spr_bus_dat_o == exp_rd)
    else note_mismatch("spr_bus_dat_o", $sampled(exp_rd), $sampled(spr_bus_dat_o));

  a_miss: assert property (@(posedge clk) disable iff (rst)
    lk_chk |-> tlb_miss_o == !ref_hit(virt_addr_match_i))
    else note_mismatch("tlb_miss_o", !ref_hit($sampled(virt_addr_match_i)),
                       $sampled(tlb_miss_o));

  a_pa: assert property (@(posedge clk) disable iff (rst)
    lk_chk |-> phys_addr_o == ref_pa(virt_addr_match_i))
    else note_mismatch("phys_addr_o", ref_pa($sampled(virt_addr_match_i)),
                       $sampled(phys_addr_o));

  a_ci: assert property (@(posedge clk) disable iff (rst)
    lk_chk |-> cache_inhibit_o == ref_ci(virt_addr_match_i))
    else note_mismatch("cache_inhibit_o", ref_ci($sampled(virt_addr_match_i)),
                       $sampled(cache_inhibit_o));

  a_fault: assert property (@(posedge clk) disable iff (rst)
    lk_chk |-> pagefault_o == ref_fault(virt_addr_match_i, op_load_i, op_store_i,
                                        supervisor_mode_i))
    else note_mismatch("pagefault_o", ref_fault($sampled(virt_addr_match_i),
                       $sampled(op_load_i), $sampled(op_store_i),
                       $sampled(supervisor_mode_i)), $sampled(pagefault_o));

  // Watchdog on the whole run
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  initial begin
    logic [31:0] d;
    logic [31:0] va;
    logic [31:0] r2;
    rst = 1'b1;
    {virt_addr_i, virt_addr_match_i, op_load_i, op_store_i, supervisor_mode_i} = '0;
    {spr_bus_addr_i, spr_bus_we_i, spr_bus_stb_i, spr_bus_dat_i} = '0;
    {exp_rd, lk_chk, pend_v, pend_ld, pend_st, pend_sup} = '0;
    {err_cnt, spr_cnt, lk_cnt, cycle_cnt} = '0;
    rnd = 32'h7e51_fb50;
    repeat (16) @(posedge clk);
    #0.5;
    rst = 1'b0;
    @(posedge clk);
    #0.5;

    // Fill every set, tag low bits equal the set, most entries valid
    for (int s = 0; s < 64; s++) begin
      rnd = xorshift(rnd);
      d = rnd;
      d[18:13] = s[5:0];
      d[0] = rnd[4:1] != 4'h0;
      m_match[s] = d;
      spr_access(tlb_spr_addr(1'b0, s[5:0]), 1'b1, d);
      rnd = xorshift(rnd);
      m_trans[s] = rnd;
      spr_access(tlb_spr_addr(1'b1, s[5:0]), 1'b1, rnd);
    end

    // Read back, match on even sets and translate on odd
    for (int s = 0; s < 64; s++) begin
      exp_rd = s[0] ? m_trans[s] : m_match[s];
      spr_access(tlb_spr_addr(s[0], s[5:0]), 1'b0, 32'h0);
    end

    // Foreign groups stay silent, group 1 outside the TLB reads zero
    strobe_no_ack(16'h0205);
    strobe_no_ack(16'h1a05);
    strobe_no_ack(16'hfa80);
    exp_rd = 32'h0;
    spr_access(16'h0805, 1'b0, 32'h0);
    spr_access(16'h0990, 1'b0, 32'h0);

    // Back-to-back lookups, hits and tag or valid misses
    for (int i = 0; i < 600; i++) begin
      rnd = xorshift(rnd);
      r2  = xorshift(rnd ^ 32'h5a5a_0f0f);
      va  = {m_match[rnd[5:0]][31:13], r2[12:0]};
      if (rnd[15:14] == 2'b00)
        va[31:19] = va[31:19] ^ (r2[31:19] | 13'h1);
      lookup(va, rnd[17:16] == 2'b01 || rnd[17:16] == 2'b11, rnd[17:16] == 2'b10,
             rnd[18], 1'b1);
    end
    // Drain the last result, then stop checking
    lookup(32'h0, 1'b0, 1'b0, 1'b0, 1'b0);
    lookup(32'h0, 1'b0, 1'b0, 1'b0, 1'b0);

    $display("Done: %0d errors, %0d SPR accesses, %0d lookups checked, %0d cycles",
             err_cnt, spr_cnt, lk_cnt, cycle_cnt);
    if (err_cnt == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

endmodule

// ==== files.f ====
dmmu_pkg.sv
dmmu_spr_if.sv
dmmu_spr_decode.sv
dmmu_tlb_ram.sv
dmmu_tlb_lookup.sv
dmmu_access_check.sv
dmmu_top.sv
tb_dmmu.sv
